//--- common/rv_pkg.sv
// RV32I pipeline shared widths, opcodes, ALU ops and stage payload structs
package rv_pkg;

  localparam int XLEN       = 32;  // Data and address width
  localparam int NUM_REGS   = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_idx_t;

  // Major opcodes, inst[6:0]
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;  // ecall

  // ecall stops the core only when a7 holds 10
  localparam reg_idx_t HALT_REG  = 5'd17;
  localparam word_t    HALT_CODE = 32'd10;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,  // Signed compare
    ALU_SLL,
    ALU_SRL
  } alu_op_e;

  // Decoded control, all zero for a bubble
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    alu_src;    // Second operand is the immediate
    logic    pc_to_reg;  // Link value pc+4 goes to rd
    logic    branch;
    logic    branch_ne;  // bne rather than beq
    logic    is_jal;
    logic    is_jalr;
    logic    is_halt;
    alu_op_e alu_op;
  } ctrl_t;

  // Decode to execute
  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    word_t    pc;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
  } id_ex_t;

  // Execute to memory
  typedef struct packed {
    logic     valid;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     is_halt;
    word_t    result;      // ALU value, address, or link pc+4
    word_t    store_data;
    reg_idx_t rd;
  } ex_mem_t;

  // Writeback bundle from the MEM/WB register
  typedef struct packed {
    logic     reg_write;
    logic     is_halt;
    reg_idx_t rd;
    word_t    value;
  } wb_t;

  // Instruction memory load port
  typedef struct packed {
    logic  strobe;
    word_t addr;  // Word address
    word_t inst;
  } imem_load_t;

endpackage

//--- decode/decode_stage.sv
// Decode stage with control decode, immediates, register file, hazard stall and ID/EX
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  word_t    if_inst,
  input  word_t    if_pc,
  input  logic     if_valid,
  input  logic     redirect,
  input  ctrl_t    ex_ctrl,
  input  reg_idx_t ex_rd,
  input  ex_mem_t  mem_fwd,
  input  wb_t      wb,
  output logic     stall,
  output id_ex_t   id_ex,
  output word_t    print_reg [NUM_REGS]
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_5;
  logic       is_ecall;
  logic       use_rs1;
  logic       use_rs2;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  ctrl_t      ctrl;
  word_t      imm;
  word_t      regs [NUM_REGS];
  word_t      rs1_val;
  word_t      rs2_val;
  logic       load_use;
  logic       x17_busy;  // Older writer of a7 still in flight
  logic       halt_now;
  logic       stop;      // Sticky once the halting ecall passes

  assign opcode   = if_inst[6:0];
  assign funct3   = if_inst[14:12];
  assign funct7_5 = if_inst[30];
  assign is_ecall = (opcode == OP_SYSTEM);
  assign rs1      = is_ecall ? HALT_REG : if_inst[19:15];  // ecall reads a7
  assign rs2      = if_inst[24:20];
  assign rd       = if_inst[11:7];

  // Control decode and immediate select
  always_comb begin
    ctrl    = '0;
    ctrl.alu_op = ALU_ADD;
    imm     = {{20{if_inst[31]}}, if_inst[31:20]};  // I-type by default
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      OP_REG, OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = (opcode == OP_IMM);
        use_rs1        = 1'b1;
        use_rs2        = (opcode == OP_REG);
        case (funct3)
          3'b000:  ctrl.alu_op = (opcode == OP_REG && funct7_5) ? ALU_SUB : ALU_ADD;
          3'b111:  ctrl.alu_op = ALU_AND;
          3'b110:  ctrl.alu_op = ALU_OR;
          3'b100:  ctrl.alu_op = ALU_XOR;
          3'b010:  ctrl.alu_op = ALU_SLT;
          3'b001:  ctrl.alu_op = ALU_SLL;
          default: ctrl.alu_op = ALU_SRL;
        endcase
      end
      OP_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.alu_src   = 1'b1;  // Address = rs1 + imm
        use_rs1        = 1'b1;
      end
      OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
        imm = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
      end
      OP_BRANCH: begin
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = funct3[0];  // bne
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
        imm = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
               if_inst[11:8], 1'b0};
      end
      OP_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.pc_to_reg = 1'b1;
        ctrl.is_jal    = 1'b1;
        imm = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12], if_inst[20],
               if_inst[30:21], 1'b0};
      end
      OP_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.pc_to_reg = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.alu_src   = 1'b1;
        use_rs1        = 1'b1;
      end
      default: ;  // ecall and unknown act as no-ops
    endcase
    ctrl.is_halt = halt_now;
  end

  // Register file, x0 never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.reg_write && wb.rd != '0) begin
      regs[wb.rd] <= wb.value;
    end
  end

  // Write-through reads
  assign rs1_val = (rs1 == '0) ? '0 :
                   (wb.reg_write && wb.rd == rs1) ? wb.value : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 :
                   (wb.reg_write && wb.rd == rs2) ? wb.value : regs[rs2];
  assign print_reg = regs;

  // Hazards
  assign load_use = ex_ctrl.mem_read && ex_rd != '0 &&
                    ((use_rs1 && ex_rd == rs1) || (use_rs2 && ex_rd == rs2));
  assign x17_busy = (ex_ctrl.reg_write && ex_rd == HALT_REG) ||
                    (mem_fwd.valid && mem_fwd.reg_write && mem_fwd.rd == HALT_REG);
  assign stall    = if_valid && !stop && (load_use || (is_ecall && x17_busy));
  assign halt_now = if_valid && !stop && !redirect && is_ecall && !x17_busy &&
                    rs1_val == HALT_CODE;

  always_ff @(posedge clk) begin
    if (reset) begin
      stop <= 1'b0;
    end else if (halt_now) begin
      stop <= 1'b1;
    end
  end

  // ID/EX, bubble on stall, flush or after halt
  always_ff @(posedge clk) begin
    if (reset || !if_valid || stall || redirect || stop) begin
      id_ex <= '0;
    end else begin
      id_ex.valid   <= 1'b1;
      id_ex.ctrl    <= ctrl;
      id_ex.pc      <= if_pc;
      id_ex.rs1_val <= rs1_val;
      id_ex.rs2_val <= rs2_val;
      id_ex.imm     <= imm;
      id_ex.rs1     <= rs1;
      id_ex.rs2     <= rs2;
      id_ex.rd      <= rd;
    end
  end

endmodule

//--- execute/execute_stage.sv
// Execute stage with operand forwarding, ALU, branch resolution and EX/MEM register
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  id_ex_t   id_ex,
  input  wb_t      wb,
  output logic     redirect,
  output word_t    redirect_pc,
  output ex_mem_t  ex_mem,
  output ctrl_t    ex_ctrl,
  output reg_idx_t ex_rd
);

  word_t fwd_a;
  word_t fwd_b;
  word_t alu_b;
  word_t alu_y;
  word_t pc_imm;
  logic  eq;
  logic  taken;
  logic  jump;

  // Newest writer wins: EX/MEM first, then writeback
  function automatic word_t forward(input reg_idx_t idx, input word_t reg_val,
                                    input ex_mem_t em, input wb_t w);
    word_t val;
    val = reg_val;
    if (em.valid && em.reg_write && em.rd != '0 && em.rd == idx) begin
      val = em.result;  // Link value already folded in
    end else if (w.reg_write && w.rd != '0 && w.rd == idx) begin
      val = w.value;
    end
    return val;
  endfunction

  assign fwd_a = forward(id_ex.rs1, id_ex.rs1_val, ex_mem, wb);
  assign fwd_b = forward(id_ex.rs2, id_ex.rs2_val, ex_mem, wb);
  assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;

  // ALU
  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_SUB: alu_y = fwd_a - alu_b;
      ALU_AND: alu_y = fwd_a & alu_b;
      ALU_OR:  alu_y = fwd_a | alu_b;
      ALU_XOR: alu_y = fwd_a ^ alu_b;
      ALU_SLT: alu_y = {31'd0, $signed(fwd_a) < $signed(alu_b)};
      ALU_SLL: alu_y = fwd_a << alu_b[4:0];
      ALU_SRL: alu_y = fwd_a >> alu_b[4:0];
      default: alu_y = fwd_a + alu_b;  // Also loads, stores and jalr
    endcase
  end

  // Branch resolution on forwarded operands
  assign eq     = (fwd_a == fwd_b);
  assign taken  = id_ex.valid && id_ex.ctrl.branch && (id_ex.ctrl.branch_ne ? !eq : eq);
  assign jump   = id_ex.valid && (id_ex.ctrl.is_jal || id_ex.ctrl.is_jalr);
  assign pc_imm = id_ex.pc + id_ex.imm;

  assign redirect    = taken || jump;
  assign redirect_pc = id_ex.ctrl.is_jalr ? {alu_y[XLEN-1:1], 1'b0} : pc_imm;

  // Seen by the decode hazard checks
  assign ex_ctrl = id_ex.valid ? id_ex.ctrl : '0;
  assign ex_rd   = id_ex.rd;

  // EX/MEM control
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.valid     <= 1'b0;
      ex_mem.reg_write <= 1'b0;
      ex_mem.mem_read  <= 1'b0;
      ex_mem.mem_write <= 1'b0;
      ex_mem.is_halt   <= 1'b0;
    end else begin
      ex_mem.valid     <= id_ex.valid;
      ex_mem.reg_write <= id_ex.valid && id_ex.ctrl.reg_write;
      ex_mem.mem_read  <= id_ex.valid && id_ex.ctrl.mem_read;
      ex_mem.mem_write <= id_ex.valid && id_ex.ctrl.mem_write;
      ex_mem.is_halt   <= id_ex.valid && id_ex.ctrl.is_halt;
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    ex_mem.result     <= id_ex.ctrl.pc_to_reg ? id_ex.pc + 32'd4 : alu_y;  // Link address
    ex_mem.store_data <= fwd_b;
    ex_mem.rd         <= id_ex.rd;
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module cpu_tb -o cpu_tb_sim
./obj_dir/cpu_tb_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
else
  exit 1
fi

//--- sim.f
common/rv_pkg.sv
src/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
src/memory_stage.sv
src/cpu.sv
tests/cpu_properties.sv
tests/cpu_tb.sv

//--- src/cpu.sv
// Five-stage RV32I pipeline top, exporting halt status and the register file
`timescale 1ns/1ps

module cpu import rv_pkg::*; #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 64
) (
  input  logic       clk,
  input  logic       reset,
  input  imem_load_t imem_load,
  output logic       is_halted,
  output word_t      print_reg [NUM_REGS]
);

  // IF/ID outputs
  word_t    if_inst;
  word_t    if_pc;
  logic     if_valid;

  logic     stall;        // Decode hazard hold
  logic     redirect;     // Taken branch or jump in execute
  word_t    redirect_pc;

  id_ex_t   id_ex;
  ex_mem_t  ex_mem;       // Also the forwarding source in execute
  ctrl_t    ex_ctrl;      // Control of the instruction in execute
  reg_idx_t ex_rd;
  wb_t      wb;

  fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
    .clk         (clk),
    .reset       (reset),
    .imem_load   (imem_load),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .if_inst     (if_inst),
    .if_pc       (if_pc),
    .if_valid    (if_valid)
  );

  decode_stage u_decode (
    .clk       (clk),
    .reset     (reset),
    .if_inst   (if_inst),
    .if_pc     (if_pc),
    .if_valid  (if_valid),
    .redirect  (redirect),
    .ex_ctrl   (ex_ctrl),
    .ex_rd     (ex_rd),
    .mem_fwd   (ex_mem),
    .wb        (wb),
    .stall     (stall),
    .id_ex     (id_ex),
    .print_reg (print_reg)
  );

  execute_stage u_execute (
    .clk         (clk),
    .reset       (reset),
    .id_ex       (id_ex),
    .wb          (wb),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ex_mem      (ex_mem),
    .ex_ctrl     (ex_ctrl),
    .ex_rd       (ex_rd)
  );

  memory_stage #(.DMEM_DEPTH(DMEM_DEPTH)) u_memory (
    .clk       (clk),
    .reset     (reset),
    .ex_mem    (ex_mem),
    .wb        (wb),
    .is_halted (is_halted)
  );

endmodule

//--- src/fetch_stage.sv
// Fetch stage with PC, loadable instruction memory and the IF/ID register
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic       clk,
  input  logic       reset,
  input  imem_load_t imem_load,
  input  logic       stall,
  input  logic       redirect,
  input  word_t      redirect_pc,
  output word_t      if_inst,
  output word_t      if_pc,
  output logic       if_valid
);

  localparam int IMEM_AW = $clog2(IMEM_DEPTH);

  word_t pc;
  word_t imem [IMEM_DEPTH];  // Word addressed
  word_t fetched;

  // Asynchronous read, byte PC to word index
  assign fetched = imem[pc[IMEM_AW+1:2]];

  // Program placed by the testbench while reset is high
  always_ff @(posedge clk) begin
    if (imem_load.strobe) begin
      imem[imem_load.addr[IMEM_AW-1:0]] <= imem_load.inst;
    end
  end

  // PC and IF/ID valid
  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= '0;
      if_valid <= 1'b0;
    end else if (redirect) begin  // Redirect beats a stall
      pc       <= redirect_pc;
      if_valid <= 1'b0;           // Wrong-path slot squashed
    end else if (!stall) begin
      pc       <= pc + 32'd4;     // Predict not taken
      if_valid <= 1'b1;
    end
  end

  // IF/ID payload, held on stall
  always_ff @(posedge clk) begin
    if (!stall) begin
      if_inst <= fetched;
      if_pc   <= pc;
    end
  end

endmodule

//--- src/memory_stage.sv
// Memory stage with single-cycle data memory, MEM/WB register and halt flag
`timescale 1ns/1ps

module memory_stage import rv_pkg::*; #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic    clk,
  input  logic    reset,
  input  ex_mem_t ex_mem,
  output wb_t     wb,
  output logic    is_halted
);

  localparam int DMEM_AW = $clog2(DMEM_DEPTH);

  word_t dmem [DMEM_DEPTH];  // Word addressed
  word_t load_data;

  assign load_data = dmem[ex_mem.result[DMEM_AW+1:2]];  // Async read

  // Data memory, cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (ex_mem.valid && ex_mem.mem_write) begin
      dmem[ex_mem.result[DMEM_AW+1:2]] <= ex_mem.store_data;
    end
  end

  // MEM/WB, selects load data or result
  always_ff @(posedge clk) begin
    if (reset) begin
      wb <= '0;
    end else begin
      wb.reg_write <= ex_mem.reg_write;
      wb.is_halt   <= ex_mem.is_halt;
      wb.rd        <= ex_mem.rd;
      wb.value     <= ex_mem.mem_read ? load_data : ex_mem.result;
    end
  end

  // Rises as the halting ecall leaves writeback
  always_ff @(posedge clk) begin
    if (reset) begin
      is_halted <= 1'b0;
    end else if (wb.is_halt) begin
      is_halted <= 1'b1;
    end
  end

endmodule

//--- tests/cpu_properties.sv
// Pipeline assertions on load-use stall, redirect, halt flag and writes after halt
`timescale 1ns/1ps

module cpu_properties (
  input logic clk,
  input logic reset,
  input logic stall,
  input logic load_use,
  input logic redirect,
  input logic is_halted,
  input logic wb_reg_write
);

  // Load-use bubble is a single cycle
  assert property (@(posedge clk) disable iff (reset)
    (stall && load_use) |=> !(stall && load_use))
    else $error("load-use stall held for two cycles");

  assert property (@(posedge clk) disable iff (reset) redirect |=> !redirect)
    else $error("redirect high on two consecutive cycles");

  assert property (@(posedge clk) disable iff (reset) is_halted |=> is_halted)
    else $error("is_halted fell without reset");

  assert property (@(posedge clk) disable iff (reset) is_halted |-> !wb_reg_write)
    else $error("register write after halt");  // Nothing younger may retire

endmodule

bind decode_stage cpu_properties u_decode_props (
  .clk(clk), .reset(reset), .stall(stall), .load_use(load_use), .redirect(redirect),
  .is_halted(1'b0), .wb_reg_write(1'b0)
);

bind memory_stage cpu_properties u_memory_props (
  .clk(clk), .reset(reset), .stall(1'b0), .load_use(1'b0), .redirect(1'b0),
  .is_halted(is_halted), .wb_reg_write(wb.reg_write)
);

//--- tests/cpu_tb.sv
// Testbench for the RV32I pipeline with random programs and an instruction-set model
`timescale 1ns/1ps

module cpu_tb import rv_pkg::*; ();

  localparam int NUM_PROGS = 8;
  localparam int PROG_LEN  = 40;
  localparam int BODY_LEN  = PROG_LEN - 2;  // Before the final addi x17 and ecall
  localparam int LOAD_LEN  = PROG_LEN + 8;  // Nop padding behind the program
  localparam int HOLD      = 20;
  localparam int LIMIT     = NUM_PROGS * (PROG_LEN * 4 + 60 + LOAD_LEN + HOLD);
  localparam word_t NOP    = 32'h00000013;
  localparam word_t ECALL  = 32'h00000073;

  logic       clk = 1'b0;
  logic       reset = 1'b1;
  imem_load_t imem_load = '0;
  logic       is_halted;
  word_t      print_reg [NUM_REGS];

  logic [31:0] seed = 32'h111a;
  word_t       prog [LOAD_LEN];
  word_t       mx [NUM_REGS];     // Model registers
  word_t       mdm [64];          // Model data memory
  word_t       snap [NUM_REGS];
  int          n;
  int          errors = 0;
  int          cycles = 0;

  cpu UUT (
    .clk       (clk),
    .reset     (reset),
    .imem_load (imem_load),
    .is_halted (is_halted),
    .print_reg (print_reg)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout: the core did not halt within %0d cycles", LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {1'b0, seed[31:1]} >> 7;
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd,
                                  input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  task automatic emit(input word_t w);
    prog[n] = w;
    n++;
  endtask

  task automatic gen_program();
    int       kind;
    int       k;
    logic     mid_done;
    logic [2:0] f3;
    reg_idx_t rd;
    reg_idx_t ra;
    reg_idx_t rb;
    logic [12:0] bo;
    logic [20:0] jo;
    logic [11:0] off;
    logic     landing [PROG_LEN];  // Slots some forward jump lands on
    n = 0;
    mid_done = 1'b0;
    for (int i = 0; i < PROG_LEN; i++) landing[i] = 1'b0;
    while (n < BODY_LEN) begin
      rd = 5'(1 + next_rand() % 15);  // x17 stays out of random writes
      ra = 5'(next_rand() % 16);
      rb = 5'(next_rand() % 16);
      k  = 2 + next_rand() % 3;
      if (n >= 20 && !mid_done && BODY_LEN - n >= 2) begin
        emit(enc_i(12'd5, 5'd0, 3'b000, HALT_REG, OP_IMM));  // ecall that must not halt
        emit(ECALL);
        mid_done = 1'b1;
        continue;
      end
      kind = next_rand() % 10;
      case (kind)
        0, 1, 2: begin
          f3 = 3'(next_rand());
          if (f3 == 3'b011) f3 = 3'b000;  // sltu not in the set
          emit({1'b0, (f3 == 3'b000) & next_rand() % 2 == 1, 5'd0, rb, ra, f3, rd, OP_REG});
        end
        3, 4: begin
          case (next_rand() % 5)
            0: f3 = 3'b000;
            1: f3 = 3'b111;
            2: f3 = 3'b110;
            3: f3 = 3'b100;
            default: f3 = 3'b010;
          endcase
          emit(enc_i(12'(next_rand()), ra, f3, rd, OP_IMM));
        end
        5: begin
          off = 12'((next_rand() % 64) * 4);
          if (BODY_LEN - n >= 3) begin  // Store, load back, use at once
            emit({off[11:5], rb, 5'd0, 3'b010, off[4:0], OP_STORE});
            emit(enc_i(off, 5'd0, 3'b010, rd, OP_LOAD));
            emit({7'd0, rd, ra, 3'b000, 5'(1 + next_rand() % 15), OP_REG});
          end else begin
            emit({off[11:5], rb, 5'd0, 3'b010, off[4:0], OP_STORE});
          end
        end
        6: emit(enc_i(12'((next_rand() % 64) * 4), 5'd0, 3'b010, rd, OP_LOAD));
        7: begin
          bo = 13'(k * 4);
          if (n + k > BODY_LEN) begin
            emit(NOP);
          end else begin
            landing[n + k] = 1'b1;
            emit({bo[12], bo[10:5], rb, ra, 2'b00, 1'(next_rand()), bo[4:1], bo[11],
                  OP_BRANCH});
          end
        end
        8: begin
          jo = 21'(k * 4);
          if (n + k > BODY_LEN) begin
            emit(NOP);
          end else begin
            landing[n + k] = 1'b1;
            emit({jo[20], jo[10:1], jo[11], jo[19:12], rd, OP_JAL});
          end
        end
        default: begin
          // A jump onto the jalr would skip the setup of its base register
          if (n + 1 + k > BODY_LEN || landing[n + 1]) begin
            emit(NOP);
          end else begin
            landing[n + 1 + k] = 1'b1;
            emit(enc_i(12'((n + 1 + k) * 4), 5'd0, 3'b000, ra == 0 ? 5'd1 : ra, OP_IMM));
            emit(enc_i(12'd0, ra == 0 ? 5'd1 : ra, 3'b000, rd, OP_JALR));
          end
        end
      endcase
    end
    emit(enc_i(12'd10, 5'd0, 3'b000, HALT_REG, OP_IMM));
    emit(ECALL);
    while (n < LOAD_LEN) emit(NOP);
  endtask

  // Sequential ISA model run to the halting ecall
  task automatic run_model();
    word_t pc;
    word_t inst;
    word_t a;
    word_t b;
    word_t val;
    word_t nxt;
    word_t im_i;
    logic  wr;
    logic  halted;
    int    steps;
    pc = 0;
    halted = 1'b0;
    steps = 0;
    for (int i = 0; i < NUM_REGS; i++) mx[i] = '0;
    for (int i = 0; i < 64; i++) mdm[i] = '0;
    while (!halted && steps < 1000) begin
      inst = prog[pc[31:2]];
      a    = mx[inst[19:15]];
      b    = mx[inst[24:20]];
      im_i = {{20{inst[31]}}, inst[31:20]};
      nxt  = pc + 4;
      wr   = 1'b0;
      val  = '0;
      case (inst[6:0])
        OP_REG, OP_IMM: begin
          if (inst[6:0] == OP_IMM) b = im_i;
          wr = 1'b1;
          case (inst[14:12])
            3'b000: val = (inst[6:0] == OP_REG && inst[30]) ? a - b : a + b;
            3'b111: val = a & b;
            3'b110: val = a | b;
            3'b100: val = a ^ b;
            3'b010: val = {31'd0, $signed(a) < $signed(b)};
            3'b001: val = a << b[4:0];
            default: val = a >> b[4:0];
          endcase
        end
        OP_LOAD: begin
          val = mdm[((a + im_i) >> 2) % 64];
          wr = 1'b1;
        end
        OP_STORE: mdm[((a + {{20{inst[31]}}, inst[31:25], inst[11:7]}) >> 2) % 64] = b;
        OP_BRANCH: begin
          if ((a == b) ^ inst[12])
            nxt = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
        OP_JAL: begin
          val = pc + 4;
          wr = 1'b1;
          nxt = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        OP_JALR: begin
          val = pc + 4;
          wr = 1'b1;
          nxt = (a + im_i) & ~32'd1;
        end
        OP_SYSTEM: halted = (mx[17] == 32'd10);
        default: ;
      endcase
      if (wr && inst[11:7] != 0) mx[inst[11:7]] = val;
      pc = nxt;
      steps++;
    end
  endtask

  initial begin
    for (int p = 0; p < NUM_PROGS; p++) begin
      gen_program();
      run_model();
      @(posedge clk) reset <= 1'b1;
      for (int w = 0; w < LOAD_LEN; w++) begin  // Load while reset is high
        @(posedge clk);
        imem_load.strobe <= 1'b1;
        imem_load.addr   <= w;
        imem_load.inst   <= prog[w];
      end
      @(posedge clk) imem_load <= '0;
      @(negedge clk);
      if (is_halted !== 1'b0) begin
        $display("[ERROR] reset prog%0d is_halted: expected %b, actual %b", p, 1'b0,
                 is_halted);
        errors++;
      end
      for (int r = 0; r < NUM_REGS; r++) begin
        if (print_reg[r] !== '0) begin
          $display("[ERROR] reset prog%0d x%0d: expected %h, actual %h", p, r, 32'd0,
                   print_reg[r]);
          errors++;
        end
      end
      @(posedge clk) reset <= 1'b0;
      @(negedge clk);
      while (!is_halted) @(negedge clk);
      for (int r = 0; r < NUM_REGS; r++) begin
        snap[r] = print_reg[r];
        if (print_reg[r] !== mx[r]) begin
          $display("[ERROR] prog%0d x%0d: expected %h, actual %h", p, r, mx[r], print_reg[r]);
          errors++;
        end
      end
      repeat (HOLD) begin
        @(negedge clk);
        if (is_halted !== 1'b1) begin
          $display("[ERROR] hold prog%0d is_halted: expected %b, actual %b", p, 1'b1,
                   is_halted);
          errors++;
        end
        for (int r = 0; r < NUM_REGS; r++) begin
          if (print_reg[r] !== snap[r]) begin
            $display("[ERROR] hold prog%0d x%0d: expected %h, actual %h", p, r, snap[r],
                     print_reg[r]);
            errors++;
          end
        end
      end
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
